/* common/chiplet_pkg.sv */
`default_nettype none

package chiplet_pkg;

    localparam int PKT_LENGTH_WIDTH = 4;
    localparam int PAYLOAD_WIDTH = 32;
    localparam int DEST_PORT_WIDTH = 2;
    localparam int ADDR_WIDTH = PAYLOAD_WIDTH - 1 - DEST_PORT_WIDTH - PKT_LENGTH_WIDTH;

    // Header view of the first flit of a packet.
    typedef struct packed {
        logic reg_access;
        logic [DEST_PORT_WIDTH-1:0] dest_port;
        logic [PKT_LENGTH_WIDTH-1:0] length;
        logic [ADDR_WIDTH-1:0] address;
    } head_payload_t;

    // Head flits decode as hdr, body flits as data.
    typedef union packed {
        head_payload_t hdr;
        logic [PAYLOAD_WIDTH-1:0] data;
    } payload_u;

    typedef struct packed {
        logic vc;
        payload_u payload;
    } flit_t;

    typedef struct packed {
        logic valid;
        flit_t flit;
    } out_flit_t;

    // Length counts the head flit too.
    function automatic logic [PKT_LENGTH_WIDTH-1:0] expected_num_flits(payload_u payload);
        return payload.hdr.length;
    endfunction

endpackage

`default_nettype wire

/* hw/buffers/flit_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module flit_fifo #(
    parameter int DEPTH = 8
) (
    input wire logic CLK,
    input wire logic nRST,
    input wire logic wen,
    input wire logic ren,
    input wire chiplet_pkg::flit_t wdata,
    output chiplet_pkg::flit_t rdata,
    output logic empty,
    output logic [$clog2(DEPTH+1)-1:0] count,
    output logic overrun,
    output logic underrun
);
    import chiplet_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    flit_t mem [DEPTH];
    logic [PTR_W-1:0] wptr;
    logic [PTR_W-1:0] rptr;
    logic full;
    logic push;
    logic pop;

    assign full = (count == ($clog2(DEPTH+1))'(DEPTH));
    assign empty = (count == '0);
    // A full FIFO still takes a write when the head leaves in the same cycle.
    assign push = wen && (!full || ren);
    assign pop = ren && !empty;

    // Head is visible without a read delay.
    assign rdata = mem[rptr];

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wptr] <= wdata;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wptr <= '0;
            rptr <= '0;
            count <= '0;
            overrun <= 1'b0;
            underrun <= 1'b0;
        end else begin
            if (push) begin
                wptr <= (wptr == PTR_W'(DEPTH - 1)) ? '0 : wptr + 1'b1;
            end
            if (pop) begin
                rptr <= (rptr == PTR_W'(DEPTH - 1)) ? '0 : rptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            overrun <= wen && full && !ren;
            underrun <= ren && empty;
        end
    end

endmodule

`default_nettype wire

/* hw/buffers/flit_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module flit_counter (
    input wire logic CLK,
    input wire logic nRST,
    input wire logic clear,
    input wire logic enable,
    input wire logic [chiplet_pkg::PKT_LENGTH_WIDTH-1:0] overflow_val,
    output logic [chiplet_pkg::PKT_LENGTH_WIDTH-1:0] count_out,
    output logic overflow_flag
);
    import chiplet_pkg::*;

    assign overflow_flag = (count_out == overflow_val);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count_out <= '0;
        end else if (clear) begin
            // An enabled cycle during clear is counted, so no event is lost.
            count_out <= enable ? PKT_LENGTH_WIDTH'(1) : '0;
        end else if (enable) begin
            count_out <= count_out + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/buffers/buffers.sv */
`timescale 1ns/1ps
`default_nettype none

module buffers #(
    parameter int NUM_BUFFERS = 2,
    parameter int NUM_OUTPORTS = 4,
    parameter int DEPTH = 8
) (
    input wire logic CLK,
    input wire logic nRST,
    input wire logic [NUM_BUFFERS-1:0] wen,
    input wire chiplet_pkg::flit_t [NUM_BUFFERS-1:0] wdata,
    input wire logic [NUM_BUFFERS-1:0] ren,
    input wire logic [NUM_BUFFERS-1:0] pipeline_granted,
    input wire logic [NUM_BUFFERS-1:0] reg_bank_granted,
    input wire logic [NUM_BUFFERS-1:0] pipeline_failed,
    output logic [NUM_BUFFERS-1:0] req_pipeline,
    output logic [NUM_BUFFERS-1:0] active,
    output logic [NUM_BUFFERS-1:0] empty,
    output chiplet_pkg::flit_t [NUM_BUFFERS-1:0] head,
    output logic [NUM_BUFFERS-1:0] available
);
    import chiplet_pkg::*;

    localparam int COUNT_W = $clog2(DEPTH+1);
    localparam logic [PKT_LENGTH_WIDTH-1:0] CREDIT_PERIOD = PKT_LENGTH_WIDTH'(3 * DEPTH / 4);

    typedef enum logic [1:0] {
        IDLE,
        PIPELINE,
        ACTIVE
    } state_t;

    typedef struct packed {
        state_t state;
        logic [PKT_LENGTH_WIDTH-1:0] length;
    } state_entry_t;

    state_entry_t [NUM_BUFFERS-1:0] state_table;
    state_entry_t [NUM_BUFFERS-1:0] next_state_table;
    logic [NUM_BUFFERS-1:0] pop;
    logic [NUM_BUFFERS-1:0] overrun;
    logic [NUM_BUFFERS-1:0] underrun;
    logic [NUM_BUFFERS-1:0][COUNT_W-1:0] count;
    logic [NUM_BUFFERS-1:0][PKT_LENGTH_WIDTH-1:0] pkt_count;

    for (genvar i = 0; i < NUM_BUFFERS; i++) begin : g_buffer
        // Register packets leave straight from the head on their grant.
        assign pop[i] = ren[i] || reg_bank_granted[i];

        flit_fifo #(
            .DEPTH(DEPTH)
        ) fifo_inst (
            .CLK(CLK),
            .nRST(nRST),
            .wen(wen[i]),
            .ren(pop[i]),
            .wdata(wdata[i]),
            .rdata(head[i]),
            .empty(empty[i]),
            .count(count[i]),
            .overrun(overrun[i]),
            .underrun(underrun[i])
        );

        flit_counter packet_counter_inst (
            .CLK(CLK),
            .nRST(nRST),
            .clear(state_table[i].state == PIPELINE),
            .enable(ren[i]),
            .overflow_val(state_table[i].length),
            .count_out(pkt_count[i]),
            .overflow_flag()
        );

        // Clears itself for one credit per 3/4 of the FIFO drained.
        flit_counter credit_counter_inst (
            .CLK(CLK),
            .nRST(nRST),
            .clear(available[i]),
            .enable(pop[i]),
            .overflow_val(CREDIT_PERIOD),
            .count_out(),
            .overflow_flag(available[i])
        );
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_BUFFERS; i++) begin
                state_table[i].state <= IDLE;
                state_table[i].length <= '0;
            end
        end else begin
            state_table <= next_state_table;
        end
    end

    always_ff @(posedge CLK) begin
        for (int i = 0; i < NUM_BUFFERS; i++) begin
            if (overrun[i]) begin
                $warning("buffer %0d overrun", i);
            end
            if (underrun[i]) begin
                $warning("buffer %0d underrun", i);
            end
        end
    end

    always_comb begin
        next_state_table = state_table;
        for (int i = 0; i < NUM_BUFFERS; i++) begin
            case (state_table[i].state)
                IDLE: begin
                    if (wen[i] || count[i] != '0) begin
                        next_state_table[i].state = PIPELINE;
                    end
                end
                PIPELINE: begin
                    if (reg_bank_granted[i]) begin
                        next_state_table[i].state = IDLE;
                    end else if (pipeline_granted[i]) begin
                        next_state_table[i].state = ACTIVE;
                        next_state_table[i].length = expected_num_flits(head[i].payload);
                    end
                end
                ACTIVE: begin
                    // Abort is only legal before the first flit, so the count is still zero.
                    if (pipeline_failed[i]) begin
                        next_state_table[i].state = PIPELINE;
                    end else if (ren[i] && (pkt_count[i] + 1'b1) == state_table[i].length) begin
                        next_state_table[i].state = IDLE;
                    end
                end
                default: begin
                    next_state_table[i].state = IDLE;
                end
            endcase
            req_pipeline[i] = (state_table[i].state == PIPELINE);
            active[i] = (state_table[i].state == ACTIVE);
        end
    end

endmodule

`default_nettype wire

/* hw/pipeline_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeline_arbiter #(
    parameter int NUM_BUFFERS = 2,
    parameter int NUM_OUTPORTS = 4
) (
    input wire logic CLK,
    input wire logic nRST,
    input wire logic [NUM_BUFFERS-1:0] req_pipeline,
    input wire logic [NUM_BUFFERS-1:0] active,
    input wire chiplet_pkg::flit_t [NUM_BUFFERS-1:0] head,
    input wire logic [NUM_OUTPORTS-1:0] out_fail,
    output logic [NUM_BUFFERS-1:0] pipeline_granted,
    output logic [NUM_BUFFERS-1:0] reg_bank_granted,
    output logic [NUM_BUFFERS-1:0] pipeline_failed,
    output logic [NUM_OUTPORTS-1:0] owned,
    output logic [NUM_OUTPORTS-1:0][((NUM_BUFFERS > 1) ? $clog2(NUM_BUFFERS) : 1)-1:0] owner_of
);
    import chiplet_pkg::*;

    localparam int IDX_W = (NUM_BUFFERS > 1) ? $clog2(NUM_BUFFERS) : 1;

    logic [IDX_W-1:0] rr_ptr;
    logic [IDX_W-1:0] grant_idx;
    logic [DEST_PORT_WIDTH-1:0] grant_port;
    logic grant_any;
    logic grant_pipe;
    logic [NUM_OUTPORTS-1:0] pending;

    // First eligible requester from the rotating pointer.
    always_comb begin
        int idx;
        head_payload_t hdr;
        pipeline_granted = '0;
        reg_bank_granted = '0;
        grant_any = 1'b0;
        grant_pipe = 1'b0;
        grant_idx = rr_ptr;
        grant_port = '0;
        for (int k = 0; k < NUM_BUFFERS; k++) begin
            idx = (int'(rr_ptr) + k) % NUM_BUFFERS;
            hdr = head[idx].payload.hdr;
            if (!grant_any && req_pipeline[idx]) begin
                if (hdr.reg_access) begin
                    reg_bank_granted[idx] = 1'b1;
                    grant_any = 1'b1;
                    grant_idx = IDX_W'(idx);
                end else if (int'(hdr.dest_port) < NUM_OUTPORTS && !owned[hdr.dest_port]) begin
                    pipeline_granted[idx] = 1'b1;
                    grant_any = 1'b1;
                    grant_pipe = 1'b1;
                    grant_idx = IDX_W'(idx);
                    grant_port = hdr.dest_port;
                end
            end
        end
    end

    always_comb begin
        pipeline_failed = '0;
        for (int p = 0; p < NUM_OUTPORTS; p++) begin
            if (out_fail[p] && owned[p]) begin
                pipeline_failed[owner_of[p]] = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rr_ptr <= '0;
            owned <= '0;
            pending <= '0;
            owner_of <= '0;
        end else begin
            for (int p = 0; p < NUM_OUTPORTS; p++) begin
                if (owned[p] && out_fail[p]) begin
                    owned[p] <= 1'b0;
                    pending[p] <= 1'b0;
                end else if (pending[p] && !active[owner_of[p]]) begin
                    // Owner has finished its packet.
                    owned[p] <= 1'b0;
                    pending[p] <= 1'b0;
                end else if (owned[p] && active[owner_of[p]]) begin
                    pending[p] <= 1'b1;
                end else if (grant_pipe && int'(grant_port) == p) begin
                    owned[p] <= 1'b1;
                    owner_of[p] <= grant_idx;
                    pending[p] <= 1'b0;
                end
            end
            if (grant_any) begin
                rr_ptr <= (grant_idx == IDX_W'(NUM_BUFFERS - 1)) ? '0 : grant_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/switch_crossbar.sv */
`timescale 1ns/1ps
`default_nettype none

module switch_crossbar #(
    parameter int NUM_BUFFERS = 2,
    parameter int NUM_OUTPORTS = 4
) (
    input wire logic [NUM_BUFFERS-1:0] active,
    input wire logic [NUM_BUFFERS-1:0] empty,
    input wire chiplet_pkg::flit_t [NUM_BUFFERS-1:0] head,
    input wire logic [NUM_OUTPORTS-1:0] owned,
    input wire logic [NUM_OUTPORTS-1:0][((NUM_BUFFERS > 1) ? $clog2(NUM_BUFFERS) : 1)-1:0] owner_of,
    input wire logic [NUM_OUTPORTS-1:0] out_ready,
    output logic [NUM_BUFFERS-1:0] ren,
    output chiplet_pkg::out_flit_t [NUM_OUTPORTS-1:0] out_port
);

    always_comb begin
        logic go;
        ren = '0;
        for (int p = 0; p < NUM_OUTPORTS; p++) begin
            go = owned[p] && active[owner_of[p]] && !empty[owner_of[p]] && out_ready[p];
            out_port[p].valid = go;
            out_port[p].flit = head[owner_of[p]];
            // Each buffer owns at most one port.
            if (go) begin
                ren[owner_of[p]] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/chiplet_input_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module chiplet_input_stage #(
    parameter int NUM_BUFFERS = 2,
    parameter int NUM_OUTPORTS = 4,
    parameter int DEPTH = 8
) (
    input wire logic CLK,
    input wire logic nRST,
    input wire logic [NUM_BUFFERS-1:0] in_wen,
    input wire chiplet_pkg::flit_t [NUM_BUFFERS-1:0] in_flit,
    input wire logic [NUM_OUTPORTS-1:0] out_ready,
    input wire logic [NUM_OUTPORTS-1:0] out_fail,
    output chiplet_pkg::out_flit_t [NUM_OUTPORTS-1:0] out_port,
    output chiplet_pkg::out_flit_t reg_port,
    output logic [NUM_BUFFERS-1:0] available
);
    import chiplet_pkg::*;

    localparam int IDX_W = (NUM_BUFFERS > 1) ? $clog2(NUM_BUFFERS) : 1;

    flit_t [NUM_BUFFERS-1:0] head;
    logic [NUM_BUFFERS-1:0] req_pipeline;
    logic [NUM_BUFFERS-1:0] active;
    logic [NUM_BUFFERS-1:0] empty;
    logic [NUM_BUFFERS-1:0] ren;
    logic [NUM_BUFFERS-1:0] pipeline_granted;
    logic [NUM_BUFFERS-1:0] reg_bank_granted;
    logic [NUM_BUFFERS-1:0] pipeline_failed;
    logic [NUM_OUTPORTS-1:0] owned;
    logic [NUM_OUTPORTS-1:0][IDX_W-1:0] owner_of;

    buffers #(
        .NUM_BUFFERS(NUM_BUFFERS),
        .NUM_OUTPORTS(NUM_OUTPORTS),
        .DEPTH(DEPTH)
    ) buffers_inst (
        .CLK(CLK),
        .nRST(nRST),
        .wen(in_wen),
        .wdata(in_flit),
        .ren(ren),
        .pipeline_granted(pipeline_granted),
        .reg_bank_granted(reg_bank_granted),
        .pipeline_failed(pipeline_failed),
        .req_pipeline(req_pipeline),
        .active(active),
        .empty(empty),
        .head(head),
        .available(available)
    );

    pipeline_arbiter #(
        .NUM_BUFFERS(NUM_BUFFERS),
        .NUM_OUTPORTS(NUM_OUTPORTS)
    ) pipeline_arbiter_inst (
        .CLK(CLK),
        .nRST(nRST),
        .req_pipeline(req_pipeline),
        .active(active),
        .head(head),
        .out_fail(out_fail),
        .pipeline_granted(pipeline_granted),
        .reg_bank_granted(reg_bank_granted),
        .pipeline_failed(pipeline_failed),
        .owned(owned),
        .owner_of(owner_of)
    );

    switch_crossbar #(
        .NUM_BUFFERS(NUM_BUFFERS),
        .NUM_OUTPORTS(NUM_OUTPORTS)
    ) switch_crossbar_inst (
        .active(active),
        .empty(empty),
        .head(head),
        .owned(owned),
        .owner_of(owner_of),
        .out_ready(out_ready),
        .ren(ren),
        .out_port(out_port)
    );

    // At most one register grant per cycle.
    always_comb begin
        reg_port.valid = |reg_bank_granted;
        reg_port.flit = '0;
        for (int b = 0; b < NUM_BUFFERS; b++) begin
            if (reg_bank_granted[b]) begin
                reg_port.flit = head[b];
            end
        end
    end

endmodule

`default_nettype wire

/* tests/chiplet_input_stage_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module chiplet_input_stage_chk #(
    parameter int NUM_BUFFERS = 2,
    parameter int NUM_OUTPORTS = 4
) (
    input wire logic CLK,
    input wire logic nRST,
    input wire logic [NUM_OUTPORTS-1:0] out_ready,
    input wire chiplet_pkg::out_flit_t [NUM_OUTPORTS-1:0] out_port,
    input wire chiplet_pkg::out_flit_t reg_port,
    input wire logic [NUM_BUFFERS-1:0] available
);
    import chiplet_pkg::*;

    logic [NUM_OUTPORTS-1:0] out_valid;
    int unsigned ready_fails = 0;
    int unsigned reg_fails = 0;
    int unsigned credit_fails = 0;

    always_comb begin
        for (int p = 0; p < NUM_OUTPORTS; p++) begin
            out_valid[p] = out_port[p].valid;
        end
    end

    // A port only carries a flit while downstream is ready.
    assert property (@(posedge CLK) disable iff (!nRST) (out_valid & ~out_ready) == '0)
        else begin
            ready_fails++;
            $error("flit on an output port whose out_ready is low");
        end

    // One register packet, one cycle on the register port.
    assert property (@(posedge CLK) disable iff (!nRST) reg_port.valid |=> !reg_port.valid)
        else begin
            reg_fails++;
            $error("reg_port valid held for more than one cycle");
        end

    // Credit pulses are single cycles.
    assert property (@(posedge CLK) disable iff (!nRST) (available & $past(available)) == '0)
        else begin
            credit_fails++;
            $error("available high in two consecutive cycles");
        end

endmodule

`default_nettype wire

/* tests/chiplet_input_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module chiplet_input_stage_tb;
    import chiplet_pkg::*;

    localparam int NUM_BUFFERS = 2;
    localparam int NUM_OUTPORTS = 4;
    localparam int DEPTH = 8;
    localparam int CREDIT_PERIOD = 3 * DEPTH / 4;
    localparam int WAIT_LIMIT = 2000;
    localparam logic [31:0] SEED = 32'd82981;

    logic CLK;
    logic nRST;
    logic [NUM_BUFFERS-1:0] in_wen;
    flit_t [NUM_BUFFERS-1:0] in_flit;
    logic [NUM_OUTPORTS-1:0] out_ready;
    logic [NUM_OUTPORTS-1:0] out_fail;
    out_flit_t [NUM_OUTPORTS-1:0] out_port;
    out_flit_t reg_port;
    logic [NUM_BUFFERS-1:0] available;

    logic [31:0] rand_state;
    logic [31:0] ready_state;
    logic random_ready;
    logic [NUM_OUTPORTS-1:0] hold_low;
    logic timed_out;
    int errors;

    // Expected flits per (buffer, port) and the flits left in the packet after each.
    flit_t exp_q [NUM_BUFFERS*NUM_OUTPORTS][$];
    int left_q [NUM_BUFFERS*NUM_OUTPORTS][$];
    flit_t reg_q [$];
    int written [NUM_BUFFERS];
    int popped [NUM_BUFFERS];
    int credits [NUM_BUFFERS];
    int remaining [NUM_OUTPORTS];
    int cur_src [NUM_OUTPORTS];

    chiplet_input_stage #(
        .NUM_BUFFERS(NUM_BUFFERS),
        .NUM_OUTPORTS(NUM_OUTPORTS),
        .DEPTH(DEPTH)
    ) chiplet_input_stage_inst (
        .CLK(CLK),
        .nRST(nRST),
        .in_wen(in_wen),
        .in_flit(in_flit),
        .out_ready(out_ready),
        .out_fail(out_fail),
        .out_port(out_port),
        .reg_port(reg_port),
        .available(available)
    );

    bind chiplet_input_stage chiplet_input_stage_chk #(
        .NUM_BUFFERS(NUM_BUFFERS),
        .NUM_OUTPORTS(NUM_OUTPORTS)
    ) chk_inst (
        .CLK(CLK),
        .nRST(nRST),
        .out_ready(out_ready),
        .out_port(out_port),
        .reg_port(reg_port),
        .available(available)
    );

    always #50 CLK = ~CLK;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] draw();
        rand_state = lcg_next(rand_state);
        return rand_state;
    endfunction

    function automatic flit_t make_flit(input int b, input int port, input int len,
                                        input logic reg_acc, input bit is_head);
        flit_t f;
        f.vc = 1'(b);
        f.payload.data = draw();
        if (is_head) begin
            f.payload.hdr.reg_access = reg_acc;
            f.payload.hdr.dest_port = DEST_PORT_WIDTH'(port);
            f.payload.hdr.length = PKT_LENGTH_WIDTH'(len);
        end
        return f;
    endfunction

    function automatic int pending_flits();
        int n;
        n = reg_q.size();
        for (int i = 0; i < NUM_BUFFERS * NUM_OUTPORTS; i++) begin
            n += exp_q[i].size();
        end
        return n;
    endfunction

    task automatic report_timeout(input string what);
        if (!timed_out) begin
            $display("Timeout at %0t: %s", $time, what);
        end
        timed_out = 1'b1;
    endtask

    // Waits for FIFO room, then writes one packet a flit per cycle.
    task automatic send_packet(input int b, input int port, input int len, input logic reg_acc);
        flit_t f;
        int waited;
        waited = 0;
        while (written[b] - popped[b] + len > DEPTH) begin
            if (timed_out || waited == WAIT_LIMIT) begin
                report_timeout($sformatf("buffer %0d never made room for a packet", b));
                return;
            end
            waited++;
            @(posedge CLK);
        end
        for (int i = 0; i < len; i++) begin
            f = make_flit(b, port, len, reg_acc, i == 0);
            if (reg_acc) begin
                reg_q.push_back(f);
            end else begin
                exp_q[b*NUM_OUTPORTS+port].push_back(f);
                left_q[b*NUM_OUTPORTS+port].push_back(len - 1 - i);
            end
            @(posedge CLK);
            #5;
            in_wen[b] = 1'b1;
            in_flit[b] = f;
            written[b]++;
        end
        @(posedge CLK);
        #5;
        in_wen[b] = 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (pending_flits() != 0) begin
            if (timed_out || waited == WAIT_LIMIT) begin
                report_timeout("flits still undelivered");
                return;
            end
            waited++;
            @(posedge CLK);
        end
        // Last credit pulse shows the cycle after the final pop.
        repeat (4) @(posedge CLK);
    endtask

    task automatic random_stream(input int b, input int count);
        logic [31:0] r;
        int len;
        int port;
        for (int n = 0; n < count; n++) begin
            r = draw();
            len = 1 + int'(r[18:16]) % 6;
            port = int'(r[21:20]);
            send_packet(b, port, len, 1'b0);
        end
    endtask

    task automatic run_directed();
        send_packet(0, 2, 5, 1'b0);
        wait_drained();
        send_packet(1, 0, 1, 1'b1);
        wait_drained();
        // Both buffers on one port, then on separate ports.
        fork
            send_packet(0, 1, 4, 1'b0);
            send_packet(1, 1, 6, 1'b0);
        join
        wait_drained();
        fork
            send_packet(0, 0, 5, 1'b0);
            send_packet(1, 3, 5, 1'b0);
        join
        wait_drained();
        // Port 3 owned but stalled, then aborted.
        @(posedge CLK);
        hold_low[3] = 1'b1;
        send_packet(0, 3, 4, 1'b0);
        out_fail[3] = 1'b1;
        @(posedge CLK);
        #5;
        out_fail[3] = 1'b0;
        @(posedge CLK);
        hold_low[3] = 1'b0;
        wait_drained();
    endtask

    // Downstream readiness is random or fully ready.
    always begin
        @(posedge CLK);
        #5;
        if (nRST) begin
            if (random_ready) begin
                ready_state = lcg_next(ready_state);
                out_ready = (ready_state[19:16] | ready_state[23:20]) & ~hold_low;
            end else begin
                out_ready = ~hold_low;
            end
        end
    end

    always @(negedge CLK) begin : monitor
        int q;
        flit_t want;
        if (nRST) begin
            for (int p = 0; p < NUM_OUTPORTS; p++) begin
                if (out_port[p].valid) begin
                    q = int'(out_port[p].flit.vc) * NUM_OUTPORTS + p;
                    popped[out_port[p].flit.vc]++;
                    if (remaining[p] > 0) begin
                        assert (int'(out_port[p].flit.vc) == cur_src[p]) else begin
                            errors++;
                            $display("Error at %0t: out_port[%0d].flit.vc expected %0d got %0d",
                                     $time, p, cur_src[p], out_port[p].flit.vc);
                        end
                    end
                    assert (exp_q[q].size() > 0) else begin
                        errors++;
                        $display("Error at %0t: out_port[%0d] sent a flit no packet expects",
                                 $time, p);
                    end
                    if (exp_q[q].size() > 0) begin
                        want = exp_q[q].pop_front();
                        remaining[p] = left_q[q].pop_front();
                        cur_src[p] = int'(out_port[p].flit.vc);
                        assert (out_port[p].flit == want) else begin
                            errors++;
                            $display("Error at %0t: out_port[%0d].flit expected %h got %h",
                                     $time, p, want, out_port[p].flit);
                        end
                    end
                end
            end
            if (reg_port.valid) begin
                popped[reg_port.flit.vc]++;
                assert (reg_q.size() > 0) else begin
                    errors++;
                    $display("Error at %0t: reg_port sent a flit no packet expects", $time);
                end
                if (reg_q.size() > 0) begin
                    want = reg_q.pop_front();
                    assert (reg_port.flit == want) else begin
                        errors++;
                        $display("Error at %0t: reg_port.flit expected %h got %h",
                                 $time, want, reg_port.flit);
                    end
                end
            end
            for (int b = 0; b < NUM_BUFFERS; b++) begin
                if (available[b]) begin
                    credits[b]++;
                end
            end
        end
    end

    initial begin
        int chk_fails;
        CLK = 1'b0;
        nRST = 1'b0;
        in_wen = '0;
        in_flit = '0;
        out_ready = '0;
        out_fail = '0;
        hold_low = '0;
        random_ready = 1'b0;
        timed_out = 1'b0;
        errors = 0;
        rand_state = SEED;
        ready_state = SEED;
        for (int b = 0; b < NUM_BUFFERS; b++) begin
            written[b] = 0;
            popped[b] = 0;
            credits[b] = 0;
        end
        for (int p = 0; p < NUM_OUTPORTS; p++) begin
            remaining[p] = 0;
            cur_src[p] = 0;
        end
        repeat (4) @(posedge CLK);
        #5;
        nRST = 1'b1;

        run_directed();
        @(posedge CLK);
        random_ready = 1'b1;
        fork
            random_stream(0, 12);
            random_stream(1, 12);
        join
        wait_drained();
        random_ready = 1'b0;

        if (!timed_out) begin
            for (int b = 0; b < NUM_BUFFERS; b++) begin
                assert (popped[b] == written[b]) else begin
                    errors++;
                    $display("Error at %0t: flits popped from buffer %0d expected %0d got %0d",
                             $time, b, written[b], popped[b]);
                end
                assert (credits[b] == written[b] / CREDIT_PERIOD) else begin
                    errors++;
                    $display("Error at %0t: available[%0d] pulses expected %0d got %0d",
                             $time, b, written[b] / CREDIT_PERIOD, credits[b]);
                end
            end
        end

        chk_fails = int'(chiplet_input_stage_inst.chk_inst.ready_fails)
                  + int'(chiplet_input_stage_inst.chk_inst.reg_fails)
                  + int'(chiplet_input_stage_inst.chk_inst.credit_fails);
        $display("Check errors: %0d, assertion failures: %0d, timeouts: %0d",
                 errors, chk_fails, int'(timed_out));
        if (errors == 0 && chk_fails == 0 && !timed_out) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* chiplet_input_stage.f */
common/chiplet_pkg.sv
hw/buffers/flit_fifo.sv
hw/buffers/flit_counter.sv
hw/buffers/buffers.sv
hw/pipeline_arbiter.sv
hw/switch_crossbar.sv
hw/chiplet_input_stage.sv
tests/chiplet_input_stage_chk.sv
tests/chiplet_input_stage_tb.sv

/* Makefile */
SIM = obj_dir/Vchiplet_input_stage_tb
SRCS = $(shell cat chiplet_input_stage.f)

.PHONY: all run clean

all: run

$(SIM): chiplet_input_stage.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --Mdir obj_dir \
		--top-module chiplet_input_stage_tb -f chiplet_input_stage.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
